//--- filelist.f
design/cpu_pkg.sv
design/bus_pkg.sv
design/wb_if.sv
design/regfile.sv
design/alu_exec.sv
design/cpu_core.sv
design/wb_arbiter.sv
design/wb_ram.sv
design/soc_top.sv
bench/tb_soc.sv

//--- bench/tb_soc.sv
`timescale 1ns/10ps

module tb_soc;

	typedef enum logic [2:0] {M_ALU, M_LDST, M_BR, M_R0, M_ARB} mode_e;

	typedef struct packed {
		cpu_pkg::opcode_e op;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [15:0]      imm;
		mode_e            mode;
	} entry_t;

	localparam int                         ACK_LIMIT  = 50;
	localparam int                         HALT_LIMIT = 5000;
	// near the top of the ram
	localparam logic [bus_pkg::ADDR_W-1:0] KNOWN_ADDR = (bus_pkg::RAM_WORDS - 4) * 4;
	localparam logic [bus_pkg::DATA_W-1:0] KNOWN_DATA = 32'ha5c3_0f96;
	localparam logic [31:0]                SENTINEL   = 32'hdead_beef;
	// the two constants a branch program can store
	localparam logic [15:0]                K_FALL     = 16'h0111;
	localparam logic [15:0]                K_TAKEN    = 16'h0222;

	logic                       clk;
	logic                       rst;
	logic                       run;
	logic                       halted;
	logic                       host_cyc;
	logic                       host_stb;
	logic                       host_we;
	logic [bus_pkg::ADDR_W-1:0] host_adr;
	logic [bus_pkg::DATA_W-1:0] host_dat_w;
	logic [bus_pkg::DATA_W-1:0] host_dat_r;
	logic                       host_ack;

	entry_t      tests[$];
	logic [31:0] prog[$];
	integer      seed = 32'h7cf35929;
	int          checks_done;

	soc_top i_soc_top (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.run        ( run        ),
		.halted     ( halted     ),
		.host_cyc   ( host_cyc   ),
		.host_stb   ( host_stb   ),
		.host_we    ( host_we    ),
		.host_adr   ( host_adr   ),
		.host_dat_w ( host_dat_w ),
		.host_dat_r ( host_dat_r ),
		.host_ack   ( host_ack   )
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks_done++;
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act));
	endtask

	// one wishbone access with the request dropped on the edge after ack
	task automatic host_access(input logic we, input logic [bus_pkg::ADDR_W-1:0] adr,
	                           input logic [bus_pkg::DATA_W-1:0] dat,
	                           output logic [bus_pkg::DATA_W-1:0] rdata);
		int n;
		@(negedge clk);
		host_cyc   = 1'b1;
		host_stb   = 1'b1;
		host_we    = we;
		host_adr   = adr;
		host_dat_w = dat;
		n = 0;
		@(negedge clk);
		while (!host_ack) begin
			n++;
			if (n > ACK_LIMIT)
				abort_run("timeout waiting for ack on the host port");
			@(negedge clk);
		end
		rdata    = host_dat_r;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we  = 1'b0;
	endtask

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [31:0] encode(input cpu_pkg::opcode_e op, input logic [3:0] rd,
	                                       input logic [3:0] rs, input logic [3:0] rt,
	                                       input logic [15:0] imm);
		return {op, rd, rs, rt, imm};
	endfunction

	// lui then addi with the upper half corrected for the sign of the low half
	task automatic load_const(input logic [3:0] r, input logic [31:0] v);
		logic [31:0] upper;
		upper = v - sext16(v[15:0]);
		prog.push_back(encode(cpu_pkg::OP_LUI, r, 4'd0, 4'd0, upper[31:16]));
		prog.push_back(encode(cpu_pkg::OP_ADDI, r, r, 4'd0, v[15:0]));
	endtask

	task automatic build_program(input entry_t t);
		logic [3:0] store_reg;
		store_reg = (t.mode == M_R0) ? 4'd0 : 4'd3;
		prog.delete();
		case (t.mode)
			M_LDST: begin
				load_const(4'd1, t.b);
				prog.push_back(encode(cpu_pkg::OP_LW, 4'd2, 4'd1, 4'd0, 16'h0000));
				prog.push_back(encode(cpu_pkg::OP_ADDI, 4'd3, 4'd2, 4'd0, t.imm));
			end
			M_BR: begin
				load_const(4'd1, t.a);
				load_const(4'd2, t.b);
				prog.push_back(encode(t.op, 4'd0, 4'd1, 4'd2, 16'd2));
				prog.push_back(encode(cpu_pkg::OP_ADDI, 4'd3, 4'd0, 4'd0, K_FALL));
				// always taken so it jumps over the next instruction
				prog.push_back(encode(cpu_pkg::OP_BEQ, 4'd0, 4'd0, 4'd0, 16'd1));
				prog.push_back(encode(cpu_pkg::OP_ADDI, 4'd3, 4'd0, 4'd0, K_TAKEN));
			end
			M_R0: begin
				prog.push_back(encode(cpu_pkg::OP_ADDI, 4'd0, 4'd0, 4'd0, t.imm));
				prog.push_back(encode(cpu_pkg::OP_LUI, 4'd0, 4'd0, 4'd0, t.imm));
			end
			default: begin
				load_const(4'd1, t.a);
				load_const(4'd2, t.b);
				prog.push_back(encode(t.op, 4'd3, 4'd1, 4'd2, t.imm));
			end
		endcase
		prog.push_back(encode(cpu_pkg::OP_SW, 4'd0, 4'd0, store_reg, bus_pkg::RESULT_ADDR[15:0]));
		prog.push_back(encode(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0000));
	endtask

	function automatic logic [31:0] expected_result(input entry_t t);
		logic taken;
		taken = (t.op == cpu_pkg::OP_BEQ) ? (t.a == t.b) : (t.a != t.b);
		case (t.mode)
			M_LDST:  return t.a + sext16(t.imm);
			M_BR:    return taken ? sext16(K_TAKEN) : sext16(K_FALL);
			M_R0:    return 32'h0;
			default: begin
				case (t.op)
					cpu_pkg::OP_ADD:  return t.a + t.b;
					cpu_pkg::OP_SUB:  return t.a - t.b;
					cpu_pkg::OP_AND:  return t.a & t.b;
					cpu_pkg::OP_OR:   return t.a | t.b;
					cpu_pkg::OP_XOR:  return t.a ^ t.b;
					cpu_pkg::OP_SLT:  return ($signed(t.a) < $signed(t.b)) ? 32'd1 : 32'd0;
					cpu_pkg::OP_ADDI: return t.a + sext16(t.imm);
					cpu_pkg::OP_LUI:  return {t.imm, 16'h0000};
					default:          return 32'h0;
				endcase
			end
		endcase
	endfunction

	task automatic add_test(input cpu_pkg::opcode_e op, input logic [31:0] a,
	                        input logic [31:0] b, input logic [15:0] imm, input mode_e mode);
		entry_t e;
		e.op   = op;
		e.a    = a;
		e.b    = b;
		e.imm  = imm;
		e.mode = mode;
		tests.push_back(e);
	endtask

	task automatic fill_tests();
		logic [31:0] r;
		logic [31:0] a;
		add_test(cpu_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 16'h0, M_ALU);
		add_test(cpu_pkg::OP_SUB, 32'h0, 32'h1, 16'h0, M_ALU);
		add_test(cpu_pkg::OP_SLT, 32'hffff_fffe, 32'h1, 16'h0, M_ALU);
		add_test(cpu_pkg::OP_SLT, 32'h5, 32'h8000_0000, 16'h0, M_ALU);
		add_test(cpu_pkg::OP_ADDI, 32'h10, 32'h0, 16'hfff0, M_ALU);
		add_test(cpu_pkg::OP_ADDI, 32'h1234_5678, 32'h0, 16'h8000, M_ALU);
		add_test(cpu_pkg::OP_LUI, 32'hffff_ffff, 32'h0, 16'hbeef, M_ALU);
		add_test(cpu_pkg::OP_LW, 32'hcafe_f00d, 32'h0000_0300, 16'hffff, M_LDST);
		add_test(cpu_pkg::OP_BEQ, 32'h55, 32'h55, 16'h0, M_BR);
		add_test(cpu_pkg::OP_BEQ, 32'h55, 32'h56, 16'h0, M_BR);
		add_test(cpu_pkg::OP_BNE, 32'h8000_0000, 32'h8000_0000, 16'h0, M_BR);
		add_test(cpu_pkg::OP_BNE, 32'h1, 32'hffff_ffff, 16'h0, M_BR);
		add_test(cpu_pkg::OP_ADDI, 32'h0, 32'h0, 16'h7abc, M_R0);
		add_test(cpu_pkg::OP_XOR, 32'h0f0f_1234, 32'hf0f0_8765, 16'h0, M_ARB);
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			add_test(cpu_pkg::opcode_e'({1'b0, r[2:0]}), $random(seed), $random(seed),
			         r[31:16], M_ALU);
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			// aligned address clear of the program, result and known word
			add_test(cpu_pkg::OP_LW, $random(seed), 32'h400 + {22'b0, r[7:0], 2'b00},
			         r[31:16], M_LDST);
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			a = $random(seed);
			add_test(r[1] ? cpu_pkg::OP_BNE : cpu_pkg::OP_BEQ, a, r[0] ? a : $random(seed),
			         16'h0, M_BR);
		end
		add_test(cpu_pkg::OP_SUB, $random(seed), $random(seed), 16'h0, M_ARB);
	endtask

	task automatic run_test(input entry_t t);
		logic [31:0] rd;
		int          n;
		@(negedge clk);
		run = 1'b0;
		build_program(t);
		foreach (prog[j])
			host_access(1'b1, 32'(j * 4), prog[j], rd);
		host_access(1'b1, bus_pkg::RESULT_ADDR, SENTINEL, rd);
		if (t.mode == M_LDST)
			host_access(1'b1, t.b, t.a, rd);
		@(negedge clk);
		run = 1'b1;
		n = 0;
		while (!halted) begin
			n++;
			if (n > HALT_LIMIT)
				abort_run("timeout waiting for the core to halt");
			// host competes with the core for the ram
			if (t.mode == M_ARB) begin
				host_access(1'b0, KNOWN_ADDR, 32'h0, rd);
				check("host_dat_r", KNOWN_DATA, rd);
			end else begin
				@(negedge clk);
			end
		end
		host_access(1'b0, bus_pkg::RESULT_ADDR, 32'h0, rd);
		check("result", expected_result(t), rd);
	endtask

	initial begin
		logic [31:0] rd;
		rst         = 1'b1;
		run         = 1'b0;
		host_cyc    = 1'b0;
		host_stb    = 1'b0;
		host_we     = 1'b0;
		host_adr    = '0;
		host_dat_w  = '0;
		checks_done = 0;
		fill_tests();
		repeat (8) @(negedge clk);
		rst = 1'b0;
		host_access(1'b1, KNOWN_ADDR, KNOWN_DATA, rd);
		foreach (tests[i])
			run_test(tests[i]);
		if (checks_done == 0) begin
			abort_run("no checks were run");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- design/soc_top.sv
`timescale 1ns/10ps

module soc_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	output logic                       halted,
	input  logic                       host_cyc,
	input  logic                       host_stb,
	input  logic                       host_we,
	input  logic [bus_pkg::ADDR_W-1:0] host_adr,
	input  logic [bus_pkg::DATA_W-1:0] host_dat_w,
	output logic [bus_pkg::DATA_W-1:0] host_dat_r,
	output logic                       host_ack
);

	wb_if host_bus ();
	wb_if ibus ();
	wb_if dbus ();
	wb_if ram_bus ();

	// host loader enters as a bus master
	assign host_bus.cyc   = host_cyc;
	assign host_bus.stb   = host_stb;
	assign host_bus.we    = host_we;
	assign host_bus.adr   = host_adr;
	assign host_bus.dat_w = host_dat_w;
	assign host_dat_r     = host_bus.dat_r;
	assign host_ack       = host_bus.ack;

	cpu_core i_cpu_core (
		.clk    ( clk    ),
		.rst    ( rst    ),
		.run    ( run    ),
		.halted ( halted ),
		.ibus   ( ibus   ),
		.dbus   ( dbus   )
	);

	wb_arbiter i_wb_arbiter (
		.clk     ( clk      ),
		.rst     ( rst      ),
		.m_host  ( host_bus ),
		.m_data  ( dbus     ),
		.m_instr ( ibus     ),
		.s       ( ram_bus  )
	);

	wb_ram i_wb_ram (
		.clk ( clk     ),
		.rst ( rst     ),
		.bus ( ram_bus )
	);

endmodule

//--- design/wb_ram.sv
`timescale 1ns/10ps

module wb_ram (
	input  logic clk,
	input  logic rst,
	wb_if.slave  bus
);

	localparam int IDX_W = $clog2(bus_pkg::RAM_WORDS);

	logic [bus_pkg::DATA_W-1:0] mem [bus_pkg::RAM_WORDS];
	logic [IDX_W-1:0]           word_idx;
	logic                       access;
	logic                       ack_q;
	logic [bus_pkg::DATA_W-1:0] rdata_q;

	// word addressed, low two bits ignored
	assign word_idx = bus.adr[IDX_W+1:2];

	// new request only while no ack is outstanding
	assign access = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we)
				mem[word_idx] <= bus.dat_w;
			rdata_q <= mem[word_idx];
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rdata_q;

endmodule

//--- design/wb_arbiter.sv
`timescale 1ns/10ps

module wb_arbiter (
	input  logic clk,
	input  logic rst,
	wb_if.slave  m_host,
	wb_if.slave  m_data,
	wb_if.slave  m_instr,
	wb_if.master s
);

	localparam int IDX_W = $clog2(bus_pkg::MASTER_NUM);

	logic [bus_pkg::MASTER_NUM-1:0] req;
	logic [bus_pkg::MASTER_NUM-1:0] own;
	logic                           gnt_valid;
	logic [IDX_W-1:0]               gnt_idx;
	logic [IDX_W-1:0]               pick_idx;

	assign req[bus_pkg::MASTER_HOST]  = m_host.cyc;
	assign req[bus_pkg::MASTER_DATA]  = m_data.cyc;
	assign req[bus_pkg::MASTER_INSTR] = m_instr.cyc;

	// lowest requesting index
	always_comb begin
		pick_idx = '0;
		for (int i = bus_pkg::MASTER_NUM - 1; i >= 0; i--)
			if (req[i])
				pick_idx = IDX_W'(i);
	end

	// rearbitrate only once the owner has let go of cyc
	always_ff @(posedge clk) begin
		if (rst) begin
			gnt_valid <= 1'b0;
			gnt_idx   <= '0;
		end else if (!gnt_valid || !req[gnt_idx]) begin
			gnt_valid <= |req;
			gnt_idx   <= pick_idx;
		end
	end

	always_comb begin
		for (int i = 0; i < bus_pkg::MASTER_NUM; i++)
			own[i] = gnt_valid && gnt_idx == IDX_W'(i);
	end

	always_comb begin
		s.cyc   = 1'b0;
		s.stb   = 1'b0;
		s.we    = 1'b0;
		s.adr   = '0;
		s.dat_w = '0;
		if (own[bus_pkg::MASTER_HOST]) begin
			s.cyc   = m_host.cyc;
			s.stb   = m_host.stb;
			s.we    = m_host.we;
			s.adr   = m_host.adr;
			s.dat_w = m_host.dat_w;
		end else if (own[bus_pkg::MASTER_DATA]) begin
			s.cyc   = m_data.cyc;
			s.stb   = m_data.stb;
			s.we    = m_data.we;
			s.adr   = m_data.adr;
			s.dat_w = m_data.dat_w;
		end else if (own[bus_pkg::MASTER_INSTR]) begin
			s.cyc   = m_instr.cyc;
			s.stb   = m_instr.stb;
			s.we    = m_instr.we;
			s.adr   = m_instr.adr;
			s.dat_w = m_instr.dat_w;
		end
	end

	// waiting masters see no ack
	assign m_host.ack    = own[bus_pkg::MASTER_HOST] & s.ack;
	assign m_data.ack    = own[bus_pkg::MASTER_DATA] & s.ack;
	assign m_instr.ack   = own[bus_pkg::MASTER_INSTR] & s.ack;
	assign m_host.dat_r  = own[bus_pkg::MASTER_HOST] ? s.dat_r : '0;
	assign m_data.dat_r  = own[bus_pkg::MASTER_DATA] ? s.dat_r : '0;
	assign m_instr.dat_r = own[bus_pkg::MASTER_INSTR] ? s.dat_r : '0;

endmodule

//--- design/cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
	input  logic clk,
	input  logic rst,
	input  logic run,
	output logic halted,
	wb_if.master ibus,
	wb_if.master dbus
);

	cpu_pkg::core_state_e state;

	logic [31:0] pc;
	logic [31:0] pc_next;
	logic [31:0] ir;

	// data access request, held stable for the whole bus cycle
	logic        mem_we;
	logic [31:0] mem_adr;
	logic [31:0] mem_wdata;

	cpu_pkg::opcode_e                op;
	logic [cpu_pkg::REG_ADDR_W-1:0] rd;
	logic [cpu_pkg::REG_ADDR_W-1:0] rs;
	logic [cpu_pkg::REG_ADDR_W-1:0] rt;
	logic [cpu_pkg::IMM_HI:0]       imm;

	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_result;
	logic [31:0] alu_mem_addr;
	logic        branch_taken;
	logic [31:0] branch_target;
	logic        is_alu_op;

	logic        rf_we;
	logic [31:0] rf_wdata;

	assign op  = cpu_pkg::opcode_e'(ir[cpu_pkg::OP_HI:cpu_pkg::OP_LO]);
	assign rd  = ir[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
	assign rs  = ir[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
	assign rt  = ir[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
	assign imm = ir[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO];

	assign pc_next   = pc + 32'd4;
	assign is_alu_op = op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
	                              cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT,
	                              cpu_pkg::OP_ADDI, cpu_pkg::OP_LUI};

	regfile i_regfile (
		.clk     ( clk      ),
		.rst     ( rst      ),
		.raddr_a ( rs       ),
		.raddr_b ( rt       ),
		.rdata_a ( rs_val   ),
		.rdata_b ( rt_val   ),
		.we      ( rf_we    ),
		.waddr   ( rd       ),
		.wdata   ( rf_wdata )
	);

	alu_exec i_alu_exec (
		.op            ( op            ),
		.rs_val        ( rs_val        ),
		.rt_val        ( rt_val        ),
		.imm           ( imm           ),
		.pc_next       ( pc_next       ),
		.result        ( alu_result    ),
		.mem_addr      ( alu_mem_addr  ),
		.branch_taken  ( branch_taken  ),
		.branch_target ( branch_target )
	);

	// writeback from execute or from a completed load
	always_comb begin
		rf_we    = 1'b0;
		rf_wdata = alu_result;
		if (state == cpu_pkg::EXEC && is_alu_op) begin
			rf_we = 1'b1;
		end else if (state == cpu_pkg::MEM && dbus.ack && !mem_we) begin
			rf_we    = 1'b1;
			rf_wdata = dbus.dat_r;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpu_pkg::IDLE;
			pc    <= cpu_pkg::RESET_PC;
		end else begin
			case (state)
				cpu_pkg::IDLE: begin
					if (run) begin
						state <= cpu_pkg::FETCH;
						pc    <= cpu_pkg::RESET_PC;
					end
				end
				cpu_pkg::FETCH: begin
					if (ibus.ack)
						state <= cpu_pkg::EXEC;
				end
				cpu_pkg::EXEC: begin
					if (op == cpu_pkg::OP_HALT) begin
						state <= cpu_pkg::HALTED;
					end else if (op == cpu_pkg::OP_LW || op == cpu_pkg::OP_SW) begin
						state <= cpu_pkg::MEM;
					end else begin
						state <= cpu_pkg::FETCH;
						pc    <= branch_taken ? branch_target : pc_next;
					end
				end
				cpu_pkg::MEM: begin
					if (dbus.ack) begin
						state <= cpu_pkg::FETCH;
						pc    <= pc_next;
					end
				end
				cpu_pkg::HALTED: begin
					if (!run)
						state <= cpu_pkg::IDLE;
				end
				default: state <= cpu_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpu_pkg::FETCH && ibus.ack)
			ir <= ibus.dat_r;
		if (state == cpu_pkg::EXEC) begin
			mem_we    <= (op == cpu_pkg::OP_SW);
			mem_adr   <= alu_mem_addr;
			mem_wdata <= rt_val;
		end
	end

	assign ibus.cyc   = (state == cpu_pkg::FETCH);
	assign ibus.stb   = (state == cpu_pkg::FETCH);
	assign ibus.we    = 1'b0;
	assign ibus.adr   = pc;
	assign ibus.dat_w = '0;

	assign dbus.cyc   = (state == cpu_pkg::MEM);
	assign dbus.stb   = (state == cpu_pkg::MEM);
	assign dbus.we    = mem_we;
	assign dbus.adr   = mem_adr;
	assign dbus.dat_w = mem_wdata;

	assign halted = (state == cpu_pkg::HALTED);

endmodule

//--- design/alu_exec.sv
`timescale 1ns/10ps

module alu_exec (
	input  cpu_pkg::opcode_e         op,
	input  logic [31:0]              rs_val,
	input  logic [31:0]              rt_val,
	input  logic [cpu_pkg::IMM_HI:0] imm,
	input  logic [31:0]              pc_next,
	output logic [31:0]              result,
	output logic [31:0]              mem_addr,
	output logic                     branch_taken,
	output logic [31:0]              branch_target
);

	logic [31:0] imm_sext;
	logic        operands_eq;

	assign imm_sext    = {{(31 - cpu_pkg::IMM_HI){imm[cpu_pkg::IMM_HI]}}, imm};
	assign operands_eq = (rs_val == rt_val);

	always_comb begin
		case (op)
			cpu_pkg::OP_ADD:  result = rs_val + rt_val;
			cpu_pkg::OP_SUB:  result = rs_val - rt_val;
			cpu_pkg::OP_AND:  result = rs_val & rt_val;
			cpu_pkg::OP_OR:   result = rs_val | rt_val;
			cpu_pkg::OP_XOR:  result = rs_val ^ rt_val;
			cpu_pkg::OP_SLT:  result = {31'b0, $signed(rs_val) < $signed(rt_val)};
			cpu_pkg::OP_ADDI: result = rs_val + imm_sext;
			// lower half cleared
			cpu_pkg::OP_LUI:  result = {imm, 16'h0000};
			default:          result = '0;
		endcase
	end

	assign mem_addr = rs_val + imm_sext;

	assign branch_taken = (op == cpu_pkg::OP_BEQ &&  operands_eq) ||
	                      (op == cpu_pkg::OP_BNE && !operands_eq);

	// word offset relative to the following instruction
	assign branch_target = pc_next + {imm_sext[29:0], 2'b00};

endmodule

//--- design/regfile.sv
`timescale 1ns/10ps

module regfile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_a,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_b,
	output logic [31:0]                   rdata_a,
	output logic [31:0]                   rdata_b,
	input  logic                          we,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
	input  logic [31:0]                   wdata
);

	logic [31:0] regs [cpu_pkg::REG_NUM];

	// r0 is never written, so it keeps its reset value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::REG_NUM; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

//--- design/wb_if.sv
`timescale 1ns/10ps

interface wb_if;

	logic                      cyc;
	logic                      stb;
	logic                      we;
	logic [bus_pkg::ADDR_W-1:0] adr;
	logic [bus_pkg::DATA_W-1:0] dat_w;
	logic [bus_pkg::DATA_W-1:0] dat_r;
	logic                      ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

//--- design/bus_pkg.sv
package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	localparam int RAM_WORDS = 1024;

	// test programs leave their result here
	localparam logic [ADDR_W-1:0] RESULT_ADDR = 32'h0000_0100;

	// lower index wins arbitration
	localparam int MASTER_HOST  = 0;
	localparam int MASTER_DATA  = 1;
	localparam int MASTER_INSTR = 2;
	localparam int MASTER_NUM   = 3;

endpackage

//--- design/cpu_pkg.sv
package cpu_pkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLT  = 4'd5,
		OP_ADDI = 4'd6,
		OP_LUI  = 4'd7,
		OP_LW   = 4'd8,
		OP_SW   = 4'd9,
		OP_BEQ  = 4'd10,
		OP_BNE  = 4'd11,
		OP_HALT = 4'd12
	} opcode_e;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		EXEC,
		MEM,
		HALTED
	} core_state_e;

	// instruction field positions
	localparam int OP_HI  = 31;
	localparam int OP_LO  = 28;
	localparam int RD_HI  = 27;
	localparam int RD_LO  = 24;
	localparam int RS_HI  = 23;
	localparam int RS_LO  = 20;
	localparam int RT_HI  = 19;
	localparam int RT_LO  = 16;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;

	localparam int REG_NUM    = 16;
	localparam int REG_ADDR_W = 4;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage
